//--- compile.f
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_fetch_ctrl.sv
verilog/rv_core.sv
test/tb_mem.sv
test/tb_core.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
		-f compile.f -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

//--- test/tb_core.sv
// Runs the fixed program from 0x80 and expects every store in order, ending with a store to 0x3fc
module tb_core;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] reset_pc  = 32'h0000_0080;
   localparam logic [31:0] done_addr = 32'h0000_03fc;

   logic        clk = 1'b0;
   logic        rst_n = 1'b0;
   logic [31:0] code_addr;
   logic [31:0] code_rdata;
   logic        code_ready;
   logic        data_req;
   logic        data_we;
   logic [31:0] data_addr;
   logic [31:0] data_wdata;
   logic [31:0] data_rdata;
   logic        data_ready;
   logic        illegal;

   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   int          err_cnt = 0;
   int          wr_idx = 0;
   int          stall_cnt = 0;
   int          ill_cnt = 0;
   logic        done = 1'b0;

   rv_core #(
      .num_regs (32),
      .reset_pc (reset_pc)
   ) i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .code_addr  (code_addr),
      .code_rdata (code_rdata),
      .code_ready (code_ready),
      .data_req   (data_req),
      .data_we    (data_we),
      .data_addr  (data_addr),
      .data_wdata (data_wdata),
      .data_rdata (data_rdata),
      .data_ready (data_ready),
      .illegal    (illegal)
   );

   tb_mem #(
      .prog_base (reset_pc)
   ) i_mem (
      .clk        (clk),
      .code_addr  (code_addr),
      .code_rdata (code_rdata),
      .code_ready (code_ready),
      .data_req   (data_req),
      .data_we    (data_we),
      .data_addr  (data_addr),
      .data_wdata (data_wdata),
      .data_rdata (data_rdata),
      .data_ready (data_ready)
   );

   initial begin
      forever #5 clk = ~clk;
   end

   task automatic add_expected(input logic [31:0] addr, input logic [31:0] data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   // ====================
   // Checks
   // ====================
   a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
      !data_req && !illegal && code_addr == reset_pc)
   else begin
      err_cnt++;
      $display("[FAIL] code_addr 0x%08h expected 0x%08h, data_req %0h illegal %0h",
               $sampled(code_addr), reset_pc, $sampled(data_req), $sampled(illegal));
   end

   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (data_req && !data_ready) |=> $stable(data_addr) && $stable(data_we)
         && $stable(data_wdata))
   else begin
      err_cnt++;
      $display("Data request changed while data_ready was low");
   end

   a_illegal_once: assert property (@(posedge clk) disable iff (!rst_n)
      illegal |-> !data_req ##1 !illegal)
   else begin
      err_cnt++;
      $display("Illegal flag lasted more than one cycle or came with a data access");
   end

   always @(posedge clk) begin
      if (rst_n && data_req && !data_ready) begin
         stall_cnt++;
      end
      if (rst_n && illegal) begin
         ill_cnt++;
      end
      if (rst_n && data_req && data_we && data_ready) begin
         if (data_addr == done_addr) begin
            done <= 1'b1;
         end else if (data_addr >= 32'h200 && data_addr < 32'h300) begin
            err_cnt++;
            $display("Store from a wrong path landed in the poisoned range");
         end else if (wr_idx >= exp_data.size()) begin
            err_cnt++;
            $display("More stores than the program should make");
         end else begin
            a_write: assert (data_wdata == exp_data[wr_idx] && data_addr == exp_addr[wr_idx])
            else begin
               err_cnt++;
               $display("[FAIL] data_wdata 0x%08h expected 0x%08h, data_addr 0x%08h expected 0x%08h",
                        data_wdata, exp_data[wr_idx], data_addr, exp_addr[wr_idx]);
            end
            wr_idx++;
         end
      end
   end

   // ====================
   // Sequence
   // ====================
   initial begin
      int          a_i;
      int          b_i;
      logic [31:0] a_w;
      logic [31:0] b_w;
      int          cyc;

      a_i = -7;
      b_i = 12;
      a_w = a_i;
      b_w = b_i;
      add_expected(32'h100, 32'h100);
      add_expected(32'h100, a_w);
      add_expected(32'h100, b_w);
      add_expected(32'h100, 32'habcde000);
      add_expected(32'h100, a_w + b_w);
      add_expected(32'h100, a_w - b_w);
      add_expected(32'h100, a_w & b_w);
      add_expected(32'h100, a_w | b_w);
      add_expected(32'h100, a_w ^ b_w);
      add_expected(32'h100, (a_i < b_i) ? 32'd1 : 32'd0);
      add_expected(32'h100, (a_w < b_w) ? 32'd1 : 32'd0);
      add_expected(32'h100, a_w & 32'h0f0);
      add_expected(32'h100, b_w | 32'hffffff00);
      add_expected(32'h100, a_w ^ 32'h055);
      add_expected(32'h100, (a_i < -6) ? 32'd1 : 32'd0);
      add_expected(32'h100, (b_w < 32'd5) ? 32'd1 : 32'd0);
      // One marker per untaken branch
      for (int k = 1; k <= 6; k++) begin
         add_expected(32'h100, k);
      end
      add_expected(32'h100, 32'h178 + 32'd4);
      add_expected(32'h100, 32'h184 + 32'd4);
      add_expected(32'h104, 32'habcde000);
      add_expected(32'h100, 32'habcde000);
      // The shift never writes x11
      add_expected(32'h100, 32'h0);

      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      cyc = 0;
      while (!done && cyc < 5000) begin
         @(posedge clk);
         cyc++;
      end
      if (!done) begin
         err_cnt++;
         $display("Timed out waiting for the store to the done address");
      end
      repeat (2) @(posedge clk);
      if (wr_idx != exp_data.size()) begin
         err_cnt++;
         $display("Program made %0d of %0d expected stores", wr_idx, exp_data.size());
      end
      if (ill_cnt != 1) begin
         err_cnt++;
         $display("Illegal flag was high for %0d cycles instead of one", ill_cnt);
      end

      $display("errors %0d, stores %0d of %0d, data stall cycles %0d, illegal cycles %0d",
               err_cnt, wr_idx, exp_data.size(), stall_cnt, ill_cnt);
      if (err_cnt == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- test/tb_mem.sv
// Code ROM and data RAM of 1 KiB each, decoded on address bits 9:2, with random ready stalls
module tb_mem #(
   parameter logic [31:0] prog_base = 32'h0000_0080
) (
   input  logic        clk,
   input  logic [31:0] code_addr,
   output logic [31:0] code_rdata,
   output logic        code_ready,
   input  logic        data_req,
   input  logic        data_we,
   input  logic [31:0] data_addr,
   input  logic [31:0] data_wdata,
   output logic [31:0] data_rdata,
   output logic        data_ready
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [31:0] rom [256];
   logic [31:0] ram [256];
   logic [31:0] addr_q = '0;
   logic [31:0] rnd = 32'h9a2c;
   int          wr_ptr;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // ====================
   // Instruction formats
   // ====================
   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_i(input int imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
      logic [11:0] iv;
      iv = imm[11:0];
      return {iv, rs1, f3, rd, op};
   endfunction

   // Word store relative to the base pointer in x10
   function automatic logic [31:0] enc_sw(input int imm, input logic [4:0] rs2);
      logic [11:0] iv;
      iv = imm[11:0];
      return {iv[11:5], rs2, 5'd10, 3'b010, iv[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_b(input int imm, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [2:0] f3);
      logic [12:0] iv;
      iv = imm[12:0];
      return {iv[12], iv[10:5], rs2, rs1, f3, iv[4:1], iv[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_j(input int imm, input logic [4:0] rd);
      logic [20:0] iv;
      iv = imm[20:0];
      return {iv[20], iv[10:1], iv[11], iv[19:12], rd, 7'b1101111};
   endfunction

   task automatic emit(input logic [31:0] w);
      rom[wr_ptr] = w;
      wr_ptr++;
   endtask

   task automatic alu_reg(input logic [6:0] f7, input logic [2:0] f3);
      emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd4));
      emit(enc_sw(0, 5'd4));
   endtask

   task automatic alu_imm(input int imm, input logic [4:0] rs1, input logic [2:0] f3);
      emit(enc_i(imm, rs1, f3, 5'd4, 7'b0010011));
      emit(enc_sw(0, 5'd4));
   endtask

   // Taken form skips a poison store, untaken form must bump the x6 marker
   task automatic branch_pair(input logic [2:0] f3, input logic [4:0] ta, input logic [4:0] tb,
                              input logic [4:0] na, input logic [4:0] nb);
      emit(enc_b(8, ta, tb, f3));
      emit(enc_sw(32'h100, 5'd0));
      emit(enc_b(8, na, nb, f3));
      emit(enc_i(1, 5'd6, 3'b000, 5'd6, 7'b0010011));
      emit(enc_sw(0, 5'd6));
   endtask

   initial begin
      for (int i = 0; i < 256; i++) begin
         // Opcode zero decodes as illegal
         rom[i] = {17'h0, i[7:0], 7'h00};
         ram[i] = 32'hd00d_0000 ^ {16'h0, i[7:0], i[7:0]};
      end
      wr_ptr = prog_base[9:2];
      emit(enc_i(32'h100, 5'd0, 3'b000, 5'd10, 7'b0010011));
      emit(enc_sw(0, 5'd10));
      emit(enc_i(-7, 5'd0, 3'b000, 5'd1, 7'b0010011));
      emit(enc_sw(0, 5'd1));
      emit(enc_i(12, 5'd0, 3'b000, 5'd2, 7'b0010011));
      emit(enc_sw(0, 5'd2));
      emit({20'habcde, 5'd3, 7'b0110111});
      emit(enc_sw(0, 5'd3));
      alu_reg(7'h00, 3'b000);
      alu_reg(7'h20, 3'b000);
      alu_reg(7'h00, 3'b111);
      alu_reg(7'h00, 3'b110);
      alu_reg(7'h00, 3'b100);
      alu_reg(7'h00, 3'b010);
      alu_reg(7'h00, 3'b011);
      alu_imm(32'hf0, 5'd1, 3'b111);
      alu_imm(-256, 5'd2, 3'b110);
      alu_imm(32'h55, 5'd1, 3'b100);
      alu_imm(-6, 5'd1, 3'b010);
      alu_imm(5, 5'd2, 3'b011);
      // x1 holds -7, x2 holds 12
      branch_pair(3'b000, 5'd1, 5'd1, 5'd1, 5'd2);
      branch_pair(3'b001, 5'd1, 5'd2, 5'd1, 5'd1);
      branch_pair(3'b100, 5'd1, 5'd2, 5'd2, 5'd1);
      branch_pair(3'b101, 5'd2, 5'd1, 5'd1, 5'd2);
      branch_pair(3'b110, 5'd2, 5'd1, 5'd1, 5'd2);
      branch_pair(3'b111, 5'd1, 5'd2, 5'd2, 5'd1);
      // JAL at 0x178, JALR at 0x184 aimed past a poison store
      emit(enc_j(8, 5'd7));
      emit(enc_sw(32'h100, 5'd0));
      emit(enc_sw(0, 5'd7));
      emit(enc_i(16, 5'd7, 3'b000, 5'd8, 7'b1100111));
      emit(enc_sw(32'h100, 5'd0));
      emit(enc_sw(0, 5'd8));
      emit(enc_sw(4, 5'd3));
      emit(enc_i(4, 5'd10, 3'b010, 5'd9, 7'b0000011));
      emit(enc_sw(0, 5'd9));
      // SLLI is outside the supported set
      emit(enc_i(1, 5'd1, 3'b001, 5'd11, 7'b0010011));
      emit(enc_sw(0, 5'd11));
      emit(enc_sw(32'h2fc, 5'd0));
      emit(enc_j(0, 5'd0));
   end

   // ====================
   // Ports
   // ====================
   initial begin
      code_ready = 1'b0;
      data_ready = 1'b0;
   end

   always @(negedge clk) begin
      rnd = xorshift(rnd);
      code_ready <= rnd[0] | rnd[1];
      data_ready <= rnd[2] | rnd[3];
   end

   always @(posedge clk) begin
      addr_q <= code_addr;
      if (data_req && data_we && data_ready) begin
         ram[data_addr[9:2]] <= data_wdata;
      end
   end

   assign code_rdata = rom[addr_q[9:2]];
   assign data_rdata = ram[data_addr[9:2]];

endmodule

//--- verilog/rv_core.sv
// Two-stage RV32I subset core with word-only data accesses and one request at a time per port
module rv_core import rv_pkg::*; #(
   parameter int    num_regs = 32,
   parameter word_t reset_pc = '0
) (
   input  logic  clk,
   input  logic  rst_n,
   output word_t code_addr,
   input  word_t code_rdata,
   input  logic  code_ready,
   output logic  data_req,
   output logic  data_we,
   output word_t data_addr,
   output word_t data_wdata,
   input  word_t data_rdata,
   input  logic  data_ready,
   output logic  illegal
);

   word_t inst;
   word_t exe_pc;
   logic  exe_valid;
   ctrl_t ctrl;
   word_t rs1_data;
   word_t rs2_data;
   word_t porta;
   word_t portb;
   word_t alu_result;
   logic  alu_cond;
   word_t wb_data;
   logic  rf_write;

   rv_fetch_ctrl #(
      .reset_pc (reset_pc)
   ) i_fetch (
      .clk        (clk),
      .rst_n      (rst_n),
      .code_rdata (code_rdata),
      .code_ready (code_ready),
      .pc_sel     (ctrl.pc_sel),
      .imm        (ctrl.imm),
      .alu_result (alu_result),
      .alu_cond   (alu_cond),
      .data_req   (data_req),
      .data_ready (data_ready),
      .code_addr  (code_addr),
      .inst       (inst),
      .exe_pc     (exe_pc),
      .exe_valid  (exe_valid)
   );

   rv_decoder i_dec (
      .inst      (inst),
      .exe_valid (exe_valid),
      .ctrl      (ctrl)
   );

   // No write-back until a pending load has its data
   assign rf_write = ctrl.reg_write && !(data_req && !data_ready);

   rv_regfile #(
      .num_regs (num_regs)
   ) i_rf (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (ctrl.rs1),
      .rs2      (ctrl.rs2),
      .rd       (ctrl.rd),
      .rd_data  (wb_data),
      .write    (rf_write),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   // ====================
   // Operands and ALU
   // ====================
   assign porta = (ctrl.porta_sel == porta_pc) ? exe_pc : rs1_data;
   assign portb = (ctrl.portb_sel == portb_imm) ? ctrl.imm : rs2_data;

   rv_alu i_alu (
      .op     (ctrl.alu_op),
      .a      (porta),
      .b      (portb),
      .result (alu_result),
      .cond   (alu_cond)
   );

   always_comb begin
      case (ctrl.wb_sel)
         wb_mem:      wb_data = data_rdata;
         wb_pc_plus4: wb_data = exe_pc + 32'd4;
         default:     wb_data = alu_result;
      endcase
   end

   // ====================
   // Data port
   // ====================
   assign data_req   = ctrl.mem_read || ctrl.mem_write;
   assign data_we    = ctrl.mem_write;
   assign data_addr  = alu_result;
   assign data_wdata = rs2_data;
   assign illegal    = ctrl.illegal;

   // Back-pressure keeps the whole request frozen
   a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (data_req && !data_ready) |=> data_req && $stable(data_addr)
         && $stable(data_we) && $stable(data_wdata));

endmodule

//--- verilog/rv_fetch_ctrl.sv
// Fetch and flow control that expects code_ready to qualify the address of the previous edge
module rv_fetch_ctrl import rv_pkg::*; #(
   parameter word_t reset_pc = '0
) (
   input  logic    clk,
   input  logic    rst_n,
   input  word_t   code_rdata,
   input  logic    code_ready,
   input  pc_sel_e pc_sel,
   input  word_t   imm,
   input  word_t   alu_result,
   input  logic    alu_cond,
   input  logic    data_req,
   input  logic    data_ready,
   output word_t   code_addr,
   output word_t   inst,
   output word_t   exe_pc,
   output logic    exe_valid
);

   fstate_e state;
   fstate_e state_next;
   word_t   pc_fetch;
   word_t   pc_next;
   word_t   target;
   logic    exe_valid_r;
   logic    jump_req;
   logic    branch_hold;
   logic    data_stall;
   logic    freeze;
   logic    taken;
   logic    fetch_valid;

   assign jump_req = (pc_sel == pc_jump) || (pc_sel == pc_branch && alu_cond);

   // Redirect waits until the code port has answered the pending address
   assign branch_hold = exe_valid_r && jump_req && !code_ready && state != st_reset;
   assign exe_valid   = exe_valid_r && !branch_hold;
   assign data_stall  = data_req && !data_ready;
   assign freeze      = data_stall || branch_hold;
   assign taken       = exe_valid && jump_req;

   assign target = (pc_sel == pc_jump) ? {alu_result[xlen-1:1], 1'b0} : exe_pc + imm;

   // ====================
   // Flow FSM
   // ====================
   always_comb begin
      fetch_valid = 1'b0;
      state_next  = state;
      case (state)
         st_reset: state_next = st_branch;
         st_cont, st_stall: begin
            if (freeze) begin
               state_next = data_stall ? st_stall : st_cont;
            end else if (taken) begin
               // Word arriving next is the wrong path
               state_next = st_branch;
            end else begin
               fetch_valid = code_ready;
               state_next  = st_cont;
            end
         end
         st_branch: begin
            fetch_valid = code_ready;
            if (code_ready) begin
               state_next = st_cont;
            end
         end
         default: state_next = st_reset;
      endcase
   end

   // Holding pc_fetch repeats the last address to the code port
   always_comb begin
      if (taken) begin
         pc_next = target;
      end else if (fetch_valid) begin
         pc_next = pc_fetch + 32'd4;
      end else begin
         pc_next = pc_fetch;
      end
   end

   assign code_addr = pc_next;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= st_reset;
         pc_fetch    <= reset_pc;
         exe_pc      <= reset_pc;
         inst        <= reset_inst;
         exe_valid_r <= 1'b1;
      end else begin
         state       <= state_next;
         pc_fetch    <= pc_next;
         exe_valid_r <= fetch_valid || freeze;
         if (fetch_valid) begin
            exe_pc <= pc_fetch;
            inst   <= code_rdata;
         end
      end
   end

   a_code_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (!code_ready && state != st_reset) |-> $stable(code_addr));

endmodule

//--- verilog/rv_regfile.sv
// Register file with combinational reads and num_regs of either 16 or 32 entries
module rv_regfile import rv_pkg::*; #(
   parameter int num_regs = 32
) (
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t rs1,
   input  reg_idx_t rs2,
   input  reg_idx_t rd,
   input  word_t    rd_data,
   input  logic     write,
   output word_t    rs1_data,
   output word_t    rs2_data
);

   localparam int idx_w = $clog2(num_regs);

   word_t regs [num_regs];

   // Entry 0 is cleared by reset and never written
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (write && rd != '0 && rd < num_regs) begin
         regs[rd[idx_w-1:0]] <= rd_data;
      end
   end

   // Indices beyond the file read as zero
   assign rs1_data = (rs1 < num_regs) ? regs[rs1[idx_w-1:0]] : '0;
   assign rs2_data = (rs2 < num_regs) ? regs[rs2[idx_w-1:0]] : '0;

   a_rd_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      write |-> rd < num_regs);

endmodule

//--- verilog/rv_alu.sv
// Combinational ALU without a shifter whose compare ops also drive the branch condition
module rv_alu import rv_pkg::*; (
   input  alu_op_e op,
   input  word_t   a,
   input  word_t   b,
   output word_t   result,
   output logic    cond
);

   logic lt_s;
   logic lt_u;

   assign lt_s = $signed(a) < $signed(b);
   assign lt_u = a < b;

   always_comb begin
      result = '0;
      cond   = 1'b0;
      case (op)
         alu_add:    result = a + b;
         alu_sub:    result = a - b;
         alu_and:    result = a & b;
         alu_or:     result = a | b;
         alu_xor:    result = a ^ b;
         alu_pass_b: result = b;
         alu_lt:     cond = lt_s;
         alu_ltu:    cond = lt_u;
         alu_eq:     cond = (a == b);
         alu_ne:     cond = (a != b);
         alu_ge:     cond = !lt_s;
         alu_geu:    cond = !lt_u;
         default:    result = '0;
      endcase
      // SLT and SLTU write the compare bit back
      if (op inside {alu_lt, alu_ltu}) begin
         result = word_t'(cond);
      end
   end

   // Op comes from an instruction register that is never left unknown
   a_op_known: assert final (!$isunknown(op));

endmodule

//--- verilog/rv_decoder.sv
// Combinational decode that flags every encoding outside the supported subset as illegal
module rv_decoder import rv_pkg::*; (
   input  word_t inst,
   input  logic  exe_valid,
   output ctrl_t ctrl
);

   logic [6:0] opcode;
   logic [2:0] func3;
   logic [6:0] func7;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;
   alu_op_e    arith_op;
   logic       arith_ok;
   alu_op_e    branch_op;
   logic       branch_ok;
   ctrl_t      dec;

   assign opcode = inst[6:0];
   assign func3  = inst[14:12];
   assign func7  = inst[31:25];

   // ====================
   // Immediates
   // ====================
   assign imm_i = {{20{inst[31]}}, inst[31:20]};
   assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
   assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
   assign imm_u = {inst[31:12], 12'b0};
   assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

   // Arithmetic func3 shared by register and immediate forms
   always_comb begin
      arith_ok = 1'b1;
      case (func3)
         f3_add:  arith_op = alu_add;
         f3_slt:  arith_op = alu_lt;
         f3_sltu: arith_op = alu_ltu;
         f3_xor:  arith_op = alu_xor;
         f3_or:   arith_op = alu_or;
         f3_and:  arith_op = alu_and;
         default: begin
            // Shift slots
            arith_op = alu_add;
            arith_ok = 1'b0;
         end
      endcase
   end

   always_comb begin
      branch_ok = 1'b1;
      case (func3)
         f3_beq:  branch_op = alu_eq;
         f3_bne:  branch_op = alu_ne;
         f3_blt:  branch_op = alu_lt;
         f3_bge:  branch_op = alu_ge;
         f3_bltu: branch_op = alu_ltu;
         f3_bgeu: branch_op = alu_geu;
         default: begin
            branch_op = alu_eq;
            branch_ok = 1'b0;
         end
      endcase
   end

   // ====================
   // Opcode decode
   // ====================
   always_comb begin
      dec           = '0;
      dec.alu_op    = alu_add;
      dec.porta_sel = porta_rs1;
      dec.portb_sel = portb_rs2;
      dec.wb_sel    = wb_alu;
      dec.pc_sel    = pc_plus4;
      dec.rs1       = inst[19:15];
      dec.rs2       = inst[24:20];
      dec.rd        = inst[11:7];
      dec.imm       = imm_i;
      case (opcode)
         op_reg: begin
            dec.reg_write = 1'b1;
            if (func7 == f7_alt) begin
               dec.alu_op  = alu_sub;
               dec.illegal = (func3 != f3_add);
            end else begin
               dec.alu_op  = arith_op;
               dec.illegal = (func7 != f7_base) || !arith_ok;
            end
         end
         op_imm: begin
            dec.alu_op    = arith_op;
            dec.portb_sel = portb_imm;
            dec.reg_write = 1'b1;
            dec.illegal   = !arith_ok;
         end
         op_lui: begin
            dec.alu_op    = alu_pass_b;
            dec.portb_sel = portb_imm;
            dec.imm       = imm_u;
            dec.reg_write = 1'b1;
         end
         op_load: begin
            dec.portb_sel = portb_imm;
            dec.wb_sel    = wb_mem;
            dec.mem_read  = 1'b1;
            dec.reg_write = 1'b1;
            dec.illegal   = (func3 != f3_word);
         end
         op_store: begin
            dec.portb_sel = portb_imm;
            dec.imm       = imm_s;
            dec.mem_write = 1'b1;
            dec.illegal   = (func3 != f3_word);
         end
         op_branch: begin
            dec.alu_op  = branch_op;
            dec.imm     = imm_b;
            dec.pc_sel  = pc_branch;
            dec.illegal = !branch_ok;
         end
         op_jal: begin
            dec.porta_sel = porta_pc;
            dec.portb_sel = portb_imm;
            dec.imm       = imm_j;
            dec.wb_sel    = wb_pc_plus4;
            dec.pc_sel    = pc_jump;
            dec.reg_write = 1'b1;
         end
         op_jalr: begin
            dec.portb_sel = portb_imm;
            dec.wb_sel    = wb_pc_plus4;
            dec.pc_sel    = pc_jump;
            dec.reg_write = 1'b1;
            dec.illegal   = (func3 != f3_jalr);
         end
         default: dec.illegal = 1'b1;
      endcase

      // An illegal word has no side effects
      if (dec.illegal) begin
         dec.reg_write = 1'b0;
         dec.mem_read  = 1'b0;
         dec.mem_write = 1'b0;
         dec.pc_sel    = pc_plus4;
      end
   end

   // Bubbles and killed wrong-path words do nothing
   always_comb begin
      ctrl           = dec;
      ctrl.reg_write = dec.reg_write && exe_valid;
      ctrl.mem_read  = dec.mem_read && exe_valid;
      ctrl.mem_write = dec.mem_write && exe_valid;
      ctrl.illegal   = dec.illegal && exe_valid;
   end

endmodule

//--- verilog/rv_pkg.sv
// Types and encodings for an RV32I subset without shifts, AUIPC, FENCE or system calls
package rv_pkg;

   // ====================
   // Widths and words
   // ====================
   localparam int xlen = 32;

   typedef logic [xlen-1:0] word_t;
   typedef logic [4:0]      reg_idx_t;

   // JAL x0,0 so execute spins on the reset PC until the first fetch lands
   localparam word_t reset_inst = 32'h0000_006f;

   // ====================
   // Encodings
   // ====================
   localparam logic [6:0] op_reg    = 7'b0110011;
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_jalr   = 7'b1100111;

   // func3 of register and immediate arithmetic
   localparam logic [2:0] f3_add  = 3'b000;
   localparam logic [2:0] f3_slt  = 3'b010;
   localparam logic [2:0] f3_sltu = 3'b011;
   localparam logic [2:0] f3_xor  = 3'b100;
   localparam logic [2:0] f3_or   = 3'b110;
   localparam logic [2:0] f3_and  = 3'b111;

   // func3 of conditional branches
   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

   // Word access and JALR are the only legal func3 of their opcodes
   localparam logic [2:0] f3_word = 3'b010;
   localparam logic [2:0] f3_jalr = 3'b000;

   localparam logic [6:0] f7_base = 7'b0000000;
   localparam logic [6:0] f7_alt  = 7'b0100000;

   // ====================
   // Control
   // ====================
   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or,
      alu_xor, alu_lt, alu_ltu, alu_eq,
      alu_ne, alu_ge, alu_geu, alu_pass_b
   } alu_op_e;

   typedef enum logic {porta_rs1, porta_pc} porta_sel_e;
   typedef enum logic {portb_rs2, portb_imm} portb_sel_e;
   typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc_plus4} wb_sel_e;
   typedef enum logic [1:0] {pc_plus4, pc_branch, pc_jump} pc_sel_e;

   typedef struct packed {
      alu_op_e    alu_op;
      porta_sel_e porta_sel;
      portb_sel_e portb_sel;
      wb_sel_e    wb_sel;
      pc_sel_e    pc_sel;
      logic       reg_write;
      logic       mem_read;
      logic       mem_write;
      logic       illegal;
      reg_idx_t   rs1;
      reg_idx_t   rs2;
      reg_idx_t   rd;
      word_t      imm;
   } ctrl_t;

   typedef enum logic [1:0] {st_reset, st_cont, st_branch, st_stall} fstate_e;

endpackage
